// File: rtl/mips_periph_pkg.sv
package mips_periph_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    localparam logic [31:0] TC0_BASE     = 32'h0000_7f00;  // First timer window
    localparam logic [31:0] TC1_BASE     = 32'h0000_7f10;  // Second timer window
    localparam logic [31:0] TC_SPAN      = 32'd16;         // Bytes per timer
    localparam logic [31:0] INT_ACK_ADDR = 32'h0000_7f20;  // Interrupt acknowledge

    // Word offsets inside a timer window
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_PRESET = 2'd1;
    localparam logic [1:0] REG_COUNT  = 2'd2;

    // Timer mode codes
    localparam logic [1:0] MODE_ONESHOT  = 2'd0;
    localparam logic [1:0] MODE_AUTOLOAD = 2'd1;

    // Timer FSM state codes
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_LOAD  = 2'd1;
    localparam logic [1:0] ST_COUNT = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////////////////////////

    // Data request from the CPU, write when any byte enable is set
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byteen;
    } cpu_bus_t;

    // Bridge to timer request
    typedef struct packed {
        logic        we;
        logic [1:0]  reg_sel;  // Word offset in the window
        logic [31:0] wdata;
    } tc_req_t;

    // Control register fields
    typedef struct packed {
        logic [27:0] rsvd;
        logic        im;      // Interrupt mask
        logic [1:0]  mode;
        logic        enable;
    } tc_ctrl_fields_t;

    // Control word as seen by the bus (raw) and by the counter (f)
    typedef union packed {
        logic [31:0]     raw;
        tc_ctrl_fields_t f;
    } tc_ctrl_t;

endpackage

// File: rtl/timer_counter.sv
`timescale 1ns/10ps

module timer_counter
    import mips_periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  tc_req_t     req,
    output logic [31:0] dout,
    output logic        irq
);

    tc_ctrl_t    ctrl_q;
    logic [31:0] preset_q;
    logic [31:0] count_q;
    logic [1:0]  state_q;
    logic        irq_hold_q;  // Latched one-shot interrupt
    logic        ctrl_wr;
    logic        preset_wr;
    logic        auto_mode;
    logic        done;
    logic        to_zero;     // Count hits zero at the coming edge

    //////////////////////////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////////////////////////

    assign ctrl_wr   = req.we && (req.reg_sel == REG_CTRL);
    assign preset_wr = req.we && (req.reg_sel == REG_PRESET);
    // Count is read only, writes to REG_COUNT fall through

    // Terminal count while running
    assign done = (state_q == ST_COUNT) && (count_q == 32'd0);

    assign to_zero = ((state_q == ST_LOAD) && (preset_q == 32'd0)) ||
                     ((state_q == ST_COUNT) && (count_q == 32'd1));

    always_comb begin
        case (ctrl_q.f.mode)
            MODE_ONESHOT:  auto_mode = 1'b0;
            MODE_AUTOLOAD: auto_mode = 1'b1;
            default:       auto_mode = 1'b0;  // Reserved codes stop like one-shot
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            ctrl_q.raw <= {28'd0, req.wdata[3:0]};  // Reserved bits read as zero
        end else if (to_zero && !auto_mode) begin
            ctrl_q.f.enable <= 1'b0;                // One-shot stops itself
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            preset_q <= '0;
        end else if (preset_wr) begin
            preset_q <= req.wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Counter FSM
    //////////////////////////////////////////////////////////////////////

    // A control write always sends the FSM back to idle, so an enabling
    // write is followed by one idle cycle and one load cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            count_q    <= '0;
            irq_hold_q <= 1'b0;
        end else if (ctrl_wr) begin
            state_q    <= ST_IDLE;
            irq_hold_q <= 1'b0;  // Acknowledge
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (ctrl_q.f.enable) begin
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    count_q <= preset_q;
                    state_q <= ST_COUNT;
                end
                ST_COUNT: begin
                    if (count_q != 32'd0) begin
                        count_q <= count_q - 32'd1;
                    end else if (auto_mode) begin
                        count_q <= preset_q;  // Reload, keep counting
                    end else begin
                        state_q    <= ST_IDLE;
                        irq_hold_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read back and interrupt
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req.reg_sel)
            REG_CTRL:   dout = ctrl_q.raw;
            REG_PRESET: dout = preset_q;
            REG_COUNT:  dout = count_q;
            default:    dout = 32'd0;
        endcase
    end

    // Auto-reload gives a single cycle pulse at terminal count,
    // one-shot holds until the next control write
    assign irq = ctrl_q.f.im && (done || irq_hold_q);

endmodule

// File: rtl/periph_bridge.sv
`timescale 1ns/10ps

module periph_bridge
    import mips_periph_pkg::*;
(
    // CPU side
    input  cpu_bus_t    cpu_req,
    output logic [31:0] cpu_rdata,
    input  logic        interrupt,
    input  logic        int_resp,

    // External memory
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_byteen,
    input  logic [31:0] mem_rdata,

    // Timers
    output tc_req_t     tc0_req,
    output tc_req_t     tc1_req,
    input  logic [31:0] tc0_dout,
    input  logic [31:0] tc1_dout
);

    logic hit_tc0;
    logic hit_tc1;
    logic hit_tc;
    logic full_word;  // All four lanes enabled
    logic int_ack;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    assign hit_tc0 = (cpu_req.addr >= TC0_BASE) &&
                     (cpu_req.addr <  TC0_BASE + TC_SPAN);
    assign hit_tc1 = (cpu_req.addr >= TC1_BASE) &&
                     (cpu_req.addr <  TC1_BASE + TC_SPAN);
    assign hit_tc  = hit_tc0 || hit_tc1;

    assign full_word = &cpu_req.byteen;

    //////////////////////////////////////////////////////////////////////
    // Timer requests
    //////////////////////////////////////////////////////////////////////

    // Partial writes to a timer are dropped
    always_comb begin
        tc0_req.we      = hit_tc0 && full_word;
        tc0_req.reg_sel = cpu_req.addr[3:2];
        tc0_req.wdata   = cpu_req.wdata;
    end

    always_comb begin
        tc1_req.we      = hit_tc1 && full_word;
        tc1_req.reg_sel = cpu_req.addr[3:2];
        tc1_req.wdata   = cpu_req.wdata;
    end

    //////////////////////////////////////////////////////////////////////
    // Read data return
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (hit_tc0) begin
            cpu_rdata = tc0_dout;
        end else if (hit_tc1) begin
            cpu_rdata = tc1_dout;
        end else begin
            cpu_rdata = mem_rdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////////////////////////

    // Interrupt response writes a byte to the acknowledge address
    assign int_ack = interrupt && int_resp;

    assign mem_wdata = cpu_req.wdata;

    always_comb begin
        if (int_ack) begin
            mem_addr   = INT_ACK_ADDR;
            mem_byteen = 4'b0001;
        end else begin
            mem_addr   = cpu_req.addr;
            mem_byteen = hit_tc ? 4'b0000 : cpu_req.byteen;  // Keep timer hits off memory
        end
    end

endmodule

// File: rtl/mips_periph.sv
`timescale 1ns/10ps

module mips_periph
    import mips_periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // CPU data bus
    input  cpu_bus_t    cpu_req,
    output logic [31:0] cpu_rdata,
    input  logic        interrupt,   // External interrupt line
    input  logic        int_resp,    // CPU is taking the interrupt
    output logic [5:0]  hw_int,

    // External memory
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_byteen,
    input  logic [31:0] mem_rdata
);

    tc_req_t     tc0_req;
    tc_req_t     tc1_req;
    logic [31:0] tc0_dout;
    logic [31:0] tc1_dout;
    logic        tc0_irq;
    logic        tc1_irq;

    //////////////////////////////////////////////////////////////////////
    // Timers
    //////////////////////////////////////////////////////////////////////

    timer_counter tc0_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (tc0_req),
        .dout  (tc0_dout),
        .irq   (tc0_irq)
    );

    timer_counter tc1_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (tc1_req),
        .dout  (tc1_dout),
        .irq   (tc1_irq)
    );

    //////////////////////////////////////////////////////////////////////
    // Bridge
    //////////////////////////////////////////////////////////////////////

    periph_bridge bridge_i (
        .cpu_req    (cpu_req),
        .cpu_rdata  (cpu_rdata),
        .interrupt  (interrupt),
        .int_resp   (int_resp),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_byteen (mem_byteen),
        .mem_rdata  (mem_rdata),
        .tc0_req    (tc0_req),
        .tc1_req    (tc1_req),
        .tc0_dout   (tc0_dout),
        .tc1_dout   (tc1_dout)
    );

    // Interrupt sources, bits 5:3 unused
    assign hw_int = {3'b000, interrupt, tc1_irq, tc0_irq};

endmodule

// File: verif/mips_periph_checker.sv
`timescale 1ns/10ps

module mips_periph_checker
    import mips_periph_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       tc0_we,
    input logic       tc1_we,
    input logic [1:0] tc0_mode,
    input logic       tc0_irq,
    input logic [5:0] hw_int
);

    int fail_count;  // Read by the testbench after every case

    initial fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // Bridge
    //////////////////////////////////////////////////////////////////////

    // Timer windows are disjoint
    write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(tc0_we && tc1_we)
    ) else begin
        $error("Both timer write strobes active in one cycle");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // Timers
    //////////////////////////////////////////////////////////////////////

    tc0_auto_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tc0_irq && tc0_mode == MODE_AUTOLOAD) |=> !(tc0_irq && tc0_mode == MODE_AUTOLOAD)
    ) else begin
        $error("Timer 0 auto-reload irq high for two cycles");
        fail_count++;
    end

    // Interrupt vector quiet while in reset
    reset_quiet: assert property (
        @(posedge clk) !rst_n |-> (hw_int == 6'd0)
    ) else begin
        $error("hw_int not zero during reset");
        fail_count++;
    end

endmodule

// Attached at the top so the bridge strobes and the timer see one clock
bind mips_periph mips_periph_checker checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tc0_we   (tc0_req.we),
    .tc1_we   (tc1_req.we),
    .tc0_mode (tc0_i.ctrl_q.f.mode),
    .tc0_irq  (tc0_irq),
    .hw_int   (hw_int)
);

// File: verif/mips_periph_tb.sv
`timescale 1ns/10ps

module mips_periph_tb
    import mips_periph_pkg::*;
();

    localparam int CASE_WORDS   = 7;    // Words per line in the cases file
    localparam int MAX_CASES    = 64;
    localparam int MAX_WAIT     = 200;  // Longest allowed wait op
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 5;    // After rising edge
    localparam int SETTLE_DELAY = 45;   // From drive to mid-cycle sample

    localparam logic [31:0] OP_END   = 32'd0;
    localparam logic [31:0] OP_WRITE = 32'd1;
    localparam logic [31:0] OP_READ  = 32'd2;
    localparam logic [31:0] OP_MEM   = 32'd3;
    localparam logic [31:0] OP_ACK   = 32'd4;
    localparam logic [31:0] OP_WAIT  = 32'd5;

    logic        clk;
    logic        rst_n;
    cpu_bus_t    cpu_req;
    logic [31:0] cpu_rdata;
    logic        interrupt;
    logic        int_resp;
    logic [5:0]  hw_int;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_byteen;
    logic [31:0] mem_rdata;

    logic [31:0] cases_mem [0:CASE_WORDS*MAX_CASES-1];
    integer      seed;
    logic [31:0] mem_word;  // Last word returned by external memory
    int          case_idx;

    mips_periph dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .cpu_rdata  (cpu_rdata),
        .interrupt  (interrupt),
        .int_resp   (int_resp),
        .hw_int     (hw_int),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_byteen (mem_byteen),
        .mem_rdata  (mem_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("MISMATCH %s: got %h, expected %h (case %0d)",
                                     name, got, exp, case_idx));
        end
    endtask

    task automatic drive_bus(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, input logic intr, input logic resp);
        cpu_req.addr   = addr;
        cpu_req.wdata  = wdata;
        cpu_req.byteen = be;
        interrupt      = intr;
        int_resp       = resp;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Case operations
    //////////////////////////////////////////////////////////////////////

    task automatic issue_write(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] be, input logic [3:0] exp_be);
        drive_bus(addr, wdata, be, 1'b0, 1'b0);
        #SETTLE_DELAY;
        check_word("mem_byteen", {28'd0, mem_byteen}, {28'd0, exp_be});
        next_cycle();  // Write lands on this edge
    endtask

    task automatic compare_read(input logic [31:0] addr, input logic [31:0] exp);
        drive_bus(addr, 32'd0, 4'd0, 1'b0, 1'b0);
        #SETTLE_DELAY;
        check_word("cpu_rdata", cpu_rdata, exp);
        next_cycle();
    endtask

    task automatic mem_passthrough(input logic [31:0] addr, input logic [31:0] wdata,
                                   input logic [3:0] be, input logic [3:0] exp_be);
        mem_word  = $random(seed);
        mem_rdata = mem_word;
        drive_bus(addr, wdata, be, 1'b0, 1'b0);
        #SETTLE_DELAY;
        check_word("mem_addr", mem_addr, addr);
        check_word("mem_wdata", mem_wdata, wdata);
        check_word("mem_byteen", {28'd0, mem_byteen}, {28'd0, exp_be});
        check_word("cpu_rdata", cpu_rdata, mem_word);
        next_cycle();
    endtask

    task automatic int_acknowledge(input logic [31:0] addr, input logic [31:0] wdata,
                                   input logic [3:0] be, input logic [31:0] exp_addr,
                                   input logic [3:0] exp_be, input logic [1:0] lines);
        drive_bus(addr, wdata, be, lines[1], lines[0]);  // {interrupt, int_resp}
        #SETTLE_DELAY;
        check_word("mem_addr", mem_addr, exp_addr);
        check_word("mem_byteen", {28'd0, mem_byteen}, {28'd0, exp_be});
        check_word("hw_int[2]", {31'd0, hw_int[2]}, {31'd0, lines[1]});
        next_cycle();
    endtask

    // Idle bus for n edges, then compare the interrupt vector
    task automatic idle_then_compare(input int n, input logic [31:0] exp);
        drive_bus(32'd0, 32'd0, 4'd0, 1'b0, 1'b0);
        if (n > MAX_WAIT) begin
            report_failure($sformatf("Wait of %0d cycles in case %0d exceeds the %0d cycle limit",
                                     n, case_idx, MAX_WAIT));
        end
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        check_word("hw_int", {26'd0, hw_int}, exp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          base;
        logic [31:0] op;
        bit          done;

        rst_n     = 1'b0;
        cpu_req   = '0;
        interrupt = 1'b0;
        int_resp  = 1'b0;
        mem_rdata = 32'd0;
        mem_word  = 32'd0;
        seed      = 32'h4099a9d6;
        case_idx  = 0;
        done      = 1'b0;

        $readmemh("verif/periph_cases.txt", cases_mem);
        if ($isunknown(cases_mem[0])) begin
            report_failure("Could not load cases from verif/periph_cases.txt");
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Idle outputs right after reset
        #SETTLE_DELAY;
        check_word("hw_int", {26'd0, hw_int}, 32'd0);
        check_word("mem_byteen", {28'd0, mem_byteen}, 32'd0);
        next_cycle();

        while (!done && case_idx < MAX_CASES) begin
            base = case_idx * CASE_WORDS;
            op   = cases_mem[base];
            case (op)
                OP_END:   done = 1'b1;
                OP_WRITE: issue_write(cases_mem[base+1], cases_mem[base+2],
                                      cases_mem[base+3][3:0], cases_mem[base+5][3:0]);
                OP_READ:  compare_read(cases_mem[base+1], cases_mem[base+4]);
                OP_MEM:   mem_passthrough(cases_mem[base+1], cases_mem[base+2],
                                          cases_mem[base+3][3:0], cases_mem[base+5][3:0]);
                OP_ACK:   int_acknowledge(cases_mem[base+1], cases_mem[base+2],
                                          cases_mem[base+3][3:0], cases_mem[base+4],
                                          cases_mem[base+5][3:0], cases_mem[base+6][1:0]);
                OP_WAIT:  idle_then_compare(int'(cases_mem[base+6]), cases_mem[base+4]);
                default: begin
                    report_failure($sformatf("Case %0d has unknown opcode %h", case_idx, op));
                end
            endcase
            assert (dut_i.checker_i.fail_count == 0) else begin
                report_failure($sformatf("Bound checker assertion failed by case %0d",
                                         case_idx));
            end
            case_idx++;
        end

        if (done) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("Cases file has no end line within the case limit");
        end
    end

endmodule

// File: build.f
rtl/mips_periph_pkg.sv
rtl/timer_counter.sv
rtl/periph_bridge.sv
rtl/mips_periph.sv
verif/mips_periph_checker.sv
verif/mips_periph_tb.sv

// File: verif/periph_cases.txt
// op addr wdata byteen expect expect_byteen arg (all hex)
// op 1 write, 2 read, 3 memory, 4 acknowledge, 5 wait arg cycles, 0 end
2 00007f00 00000000 0 00000000 0 0
2 00007f18 00000000 0 00000000 0 0
1 00007f04 00000005 f 00000000 0 0
2 00007f04 00000000 0 00000005 0 0
1 00007f14 00000007 f 00000000 0 0
2 00007f14 00000000 0 00000007 0 0
1 00007f04 000000aa 3 00000000 0 0
2 00007f04 00000000 0 00000005 0 0
1 00007f00 00000008 f 00000000 0 0
2 00007f00 00000000 0 00000008 0 0
1 00007f10 0000000f 8 00000000 0 0
2 00007f10 00000000 0 00000000 0 0
1 00007f10 0000000a f 00000000 0 0
2 00007f10 00000000 0 0000000a 0 0
1 00007f0c ffffffff f 00000000 0 0
1 00007f00 00000009 f 00000000 0 0
5 00000000 00000000 0 00000000 0 6
5 00000000 00000000 0 00000001 0 1
5 00000000 00000000 0 00000001 0 5
2 00007f00 00000000 0 00000008 0 0
2 00007f08 00000000 0 00000000 0 0
1 00007f00 00000008 f 00000000 0 0
5 00000000 00000000 0 00000000 0 1
1 00007f10 00000009 f 00000000 0 0
5 00000000 00000000 0 00000000 0 8
5 00000000 00000000 0 00000002 0 1
2 00007f10 00000000 0 00000008 0 0
1 00007f10 00000000 f 00000000 0 0
5 00000000 00000000 0 00000000 0 1
1 00007f04 00000003 f 00000000 0 0
1 00007f00 0000000b f 00000000 0 0
5 00000000 00000000 0 00000000 0 4
5 00000000 00000000 0 00000001 0 1
5 00000000 00000000 0 00000000 0 1
5 00000000 00000000 0 00000000 0 2
5 00000000 00000000 0 00000001 0 1
5 00000000 00000000 0 00000000 0 1
5 00000000 00000000 0 00000001 0 3
1 00007f00 00000003 f 00000000 0 0
5 00000000 00000000 0 00000000 0 4
5 00000000 00000000 0 00000000 0 1
2 00007f08 00000000 0 00000000 0 0
2 00007f08 00000000 0 00000003 0 0
2 00007f08 00000000 0 00000002 0 0
5 00000000 00000000 0 00000000 0 1
1 00007f00 00000000 f 00000000 0 0
5 00000000 00000000 0 00000000 0 1
3 00001000 12345678 f 00000000 f 0
3 00002004 cafef00d 1 00000000 1 0
3 00007efc 00000000 0 00000000 0 0
3 00007f20 deadbeef 3 00000000 3 0
4 00001000 11111111 f 00007f20 1 3
4 00007f04 00000000 0 00007f20 1 3
4 00003000 00000000 2 00003000 2 2
4 00003000 00000000 2 00003000 2 1
0 00000000 00000000 0 00000000 0 0
